//--- hdl/mem_geom_pkg.sv
`default_nettype none

package mem_geom_pkg;

	localparam int WORD_W      = 16;
	localparam int LINE_W      = 64;
	localparam int ADDR_W      = 16;
	// Word address minus the two offset bits
	localparam int LINE_ADDR_W = 14;

	typedef logic [WORD_W-1:0]      word_t;
	typedef logic [LINE_W-1:0]      line_t;
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;

	// Word within a line with word 0 in bits [15:0]
	typedef logic [1:0]             offset_t;

endpackage

`default_nettype wire

//--- hdl/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

	// Processor port with the same layout for fetch and data
	typedef struct packed {
		logic                              valid;
		logic                              write;
		logic [mem_geom_pkg::ADDR_W-1:0]   addr;
		mem_geom_pkg::word_t               wdata;
	} cpu_req_t;

	typedef enum logic {
		READ_LINE,
		WRITE_LINE
	} mem_op_e;

	typedef struct packed {
		mem_op_e                  op;
		mem_geom_pkg::line_addr_t addr;
		mem_geom_pkg::line_t      wdata;
	} mem_req_t;

	typedef struct packed {
		mem_geom_pkg::line_t line;
	} mem_rsp_t;

	// Line currently sitting at the requested index
	typedef struct packed {
		logic                     dirty;
		mem_geom_pkg::line_addr_t addr;
		mem_geom_pkg::line_t      data;
	} victim_t;

endpackage

`default_nettype wire

//--- hdl/direct_cache.sv
`timescale 1ns/1ps
`default_nettype none

module direct_cache #(
	parameter int INDEX_W  = 6,
	parameter bit WRITABLE = 1'b1
) (
	input  wire                             clk,
	input  wire                             i_arst_n,
	input  wire mem_bus_pkg::cpu_req_t      i_req,
	output mem_geom_pkg::word_t             o_rdata,
	output logic                            o_hit,
	output logic                            o_miss,
	output mem_bus_pkg::victim_t            o_victim,
	input  wire                             i_fill_valid,
	input  wire mem_geom_pkg::line_t        i_fill_line
);

	localparam int SETS  = 1 << INDEX_W;
	localparam int TAG_W = mem_geom_pkg::LINE_ADDR_W - INDEX_W;
	localparam int WW    = mem_geom_pkg::WORD_W;

	mem_geom_pkg::line_addr_t req_line;
	mem_geom_pkg::offset_t    req_off;
	logic [INDEX_W-1:0]       req_idx;
	logic [TAG_W-1:0]         req_tag;

	logic [TAG_W-1:0]         tag_q [SETS];
	mem_geom_pkg::line_t      line_q [SETS];
	logic [SETS-1:0]          valid_q;
	logic [SETS-1:0]          dirty_q;

	mem_geom_pkg::line_t      cur_line;
	mem_geom_pkg::line_t      merged_line;
	logic                     store_hit;

	assign req_line = i_req.addr[mem_geom_pkg::ADDR_W-1:2];
	assign req_off  = i_req.addr[1:0];
	assign req_idx  = req_line[INDEX_W-1:0];
	assign req_tag  = req_line[mem_geom_pkg::LINE_ADDR_W-1:INDEX_W];
	assign cur_line = line_q[req_idx];

	assign o_hit   = i_req.valid && valid_q[req_idx] && (tag_q[req_idx] == req_tag);
	assign o_miss  = i_req.valid && !o_hit;
	assign o_rdata = cur_line[req_off*WW +: WW];

	assign o_victim = '{
		dirty: valid_q[req_idx] && dirty_q[req_idx],
		addr:  {tag_q[req_idx], req_idx},
		data:  cur_line
	};

	// Store word replaces one slot of the resident line
	always_comb begin
		merged_line = cur_line;
		merged_line[req_off*WW +: WW] = i_req.wdata;
	end

	assign store_hit = WRITABLE && o_hit && i_req.write;

	always_ff @(posedge clk) begin
		if (i_fill_valid) begin
			line_q[req_idx] <= i_fill_line;
			tag_q[req_idx]  <= req_tag;
		end else if (store_hit) begin
			line_q[req_idx] <= merged_line;
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_q <= '0;
		end else if (i_fill_valid) begin
			valid_q[req_idx] <= 1'b1;
		end
	end

	generate
		if (WRITABLE) begin : g_dirty
			always_ff @(posedge clk or negedge i_arst_n) begin
				if (!i_arst_n) begin
					dirty_q <= '0;
				end else if (i_fill_valid) begin
					dirty_q[req_idx] <= 1'b0;
				end else if (store_hit) begin
					dirty_q[req_idx] <= 1'b1;
				end
			end
		end else begin : g_read_only
			assign dirty_q = '0;

			// Fetch port only ever reads
			a_no_write: assert property (@(posedge clk) disable iff (!i_arst_n)
				i_req.valid |-> !i_req.write);
		end
	endgenerate

	// Controller only refills a line that is still being waited on
	a_fill_on_miss: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_fill_valid |-> o_miss);

endmodule

`default_nettype wire

//--- hdl/miss_controller.sv
`timescale 1ns/1ps
`default_nettype none

module miss_controller #(
	parameter int MEM_CREDITS = 2
) (
	input  wire                             clk,
	input  wire                             i_arst_n,
	input  wire                             i_d_miss,
	input  wire mem_bus_pkg::victim_t       i_d_victim,
	input  wire                             i_i_miss,
	input  wire mem_geom_pkg::line_addr_t   i_i_addr,
	input  wire mem_geom_pkg::line_addr_t   i_d_addr,
	output logic                            o_d_fill_valid,
	output logic                            o_i_fill_valid,
	output mem_geom_pkg::line_t             o_fill_line,
	output logic                            o_mem_req_valid,
	output mem_bus_pkg::mem_req_t           o_mem_req,
	input  wire                             i_rsp_valid,
	input  wire mem_bus_pkg::mem_rsp_t      i_rsp,
	input  wire                             i_credit
);

	localparam int CRED_W = $clog2(MEM_CREDITS + 1);

	typedef enum logic [1:0] {
		IDLE,
		WRITEBACK,
		REFILL,
		WAIT_RSP
	} state_e;

	state_e            state_q;
	logic              serve_d_q;
	logic [CRED_W-1:0] credits_q;
	logic              have_credit;
	logic              issue;
	logic              fill;

	assign have_credit = (credits_q != '0);
	assign issue       = have_credit && ((state_q == WRITEBACK) || (state_q == REFILL));

	assign o_mem_req_valid = issue;

	always_comb begin
		o_mem_req.wdata = i_d_victim.data;
		if (state_q == WRITEBACK) begin
			o_mem_req.op   = mem_bus_pkg::WRITE_LINE;
			o_mem_req.addr = i_d_victim.addr;
		end else begin
			o_mem_req.op   = mem_bus_pkg::READ_LINE;
			o_mem_req.addr = serve_d_q ? i_d_addr : i_i_addr;
		end
	end

	// Only one READ_LINE is ever outstanding, so any response is ours
	assign fill           = (state_q == WAIT_RSP) && i_rsp_valid;
	assign o_d_fill_valid = fill && serve_d_q;
	assign o_i_fill_valid = fill && !serve_d_q;
	assign o_fill_line    = i_rsp.line;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q   <= IDLE;
			serve_d_q <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					// Data side wins a tie
					if (i_d_miss) begin
						serve_d_q <= 1'b1;
						state_q   <= i_d_victim.dirty ? WRITEBACK : REFILL;
					end else if (i_i_miss) begin
						serve_d_q <= 1'b0;
						state_q   <= REFILL;
					end
				end
				WRITEBACK: begin
					if (have_credit) begin
						state_q <= REFILL;
					end
				end
				REFILL: begin
					if (have_credit) begin
						state_q <= WAIT_RSP;
					end
				end
				WAIT_RSP: begin
					if (i_rsp_valid) begin
						state_q <= IDLE;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			credits_q <= CRED_W'(MEM_CREDITS);
		end else begin
			credits_q <= credits_q + CRED_W'(i_credit) - CRED_W'(issue);
		end
	end

	// Memory hands back no more credits than were taken
	a_credit_bound: assert property (@(posedge clk) disable iff (!i_arst_n)
		credits_q <= CRED_W'(MEM_CREDITS));

	// Read data only comes back while a refill is awaited
	a_rsp_when_waiting: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_rsp_valid |-> (state_q == WAIT_RSP));

endmodule

`default_nettype wire

//--- hdl/unified_mem.sv
`timescale 1ns/1ps
`default_nettype none

module unified_mem #(
	parameter int MEM_LAT     = 4,
	parameter int MEM_CREDITS = 2
) (
	input  wire                             clk,
	input  wire                             i_arst_n,
	input  wire                             i_req_valid,
	input  wire mem_bus_pkg::mem_req_t      i_req,
	output logic                            o_rsp_valid,
	output mem_bus_pkg::mem_rsp_t           o_rsp,
	output logic                            o_credit
);

	localparam int LINES = 1 << mem_geom_pkg::LINE_ADDR_W;

	mem_geom_pkg::line_t   mem_q [LINES] = '{default: '0};
	logic [MEM_LAT-1:0]    pipe_vld_q;
	mem_bus_pkg::mem_req_t pipe_req_q [MEM_LAT];
	mem_bus_pkg::mem_req_t out_req;

	assign out_req = pipe_req_q[MEM_LAT-1];

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pipe_vld_q <= '0;
		end else begin
			pipe_vld_q <= (pipe_vld_q << 1) | MEM_LAT'(i_req_valid);
		end
	end

	always_ff @(posedge clk) begin
		pipe_req_q[0] <= i_req;
		for (int s = 1; s < MEM_LAT; s++) begin
			pipe_req_q[s] <= pipe_req_q[s-1];
		end
	end

	// Array is touched only at the last stage, keeping requests in order
	always_ff @(posedge clk) begin
		if (pipe_vld_q[MEM_LAT-1] && (out_req.op == mem_bus_pkg::WRITE_LINE)) begin
			mem_q[out_req.addr] <= out_req.wdata;
		end
	end

	assign o_credit    = pipe_vld_q[MEM_LAT-1];
	assign o_rsp_valid = o_credit && (out_req.op == mem_bus_pkg::READ_LINE);
	assign o_rsp       = '{line: mem_q[out_req.addr]};

	a_occupancy: assert property (@(posedge clk) disable iff (!i_arst_n)
		$countones(pipe_vld_q) <= MEM_CREDITS);

endmodule

`default_nettype wire

//--- hdl/mem_hierarchy.sv
`timescale 1ns/1ps
`default_nettype none

module mem_hierarchy #(
	parameter int INDEX_W     = 6,
	parameter int MEM_LAT     = 4,
	parameter int MEM_CREDITS = 2
) (
	input  wire                             clk,
	input  wire                             i_arst_n,
	input  wire mem_bus_pkg::cpu_req_t      i_ifetch,
	output mem_geom_pkg::word_t             o_instr,
	output logic                            o_i_rdy,
	input  wire mem_bus_pkg::cpu_req_t      i_dacc,
	output mem_geom_pkg::word_t             o_d_rd_data,
	output logic                            o_d_rdy
);

	logic                  icache_miss;
	logic                  dcache_miss;
	logic                  icache_fill;
	logic                  dcache_fill;
	mem_bus_pkg::victim_t  d_victim;
	mem_geom_pkg::line_t   fill_line;
	logic                  mem_req_valid;
	mem_bus_pkg::mem_req_t mem_req;
	logic                  rsp_valid;
	mem_bus_pkg::mem_rsp_t rsp;
	logic                  credit;

	// Instruction side, never dirty so its victim is not needed
	direct_cache #(
		.INDEX_W  (INDEX_W),
		.WRITABLE (1'b0)
	) u_icache (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_req        (i_ifetch),
		.o_rdata      (o_instr),
		.o_hit        (o_i_rdy),
		.o_miss       (icache_miss),
		.o_victim     (),
		.i_fill_valid (icache_fill),
		.i_fill_line  (fill_line)
	);

	direct_cache #(
		.INDEX_W  (INDEX_W),
		.WRITABLE (1'b1)
	) u_dcache (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_req        (i_dacc),
		.o_rdata      (o_d_rd_data),
		.o_hit        (o_d_rdy),
		.o_miss       (dcache_miss),
		.o_victim     (d_victim),
		.i_fill_valid (dcache_fill),
		.i_fill_line  (fill_line)
	);

	miss_controller #(
		.MEM_CREDITS (MEM_CREDITS)
	) u_miss_ctrl (
		.clk             (clk),
		.i_arst_n        (i_arst_n),
		.i_d_miss        (dcache_miss),
		.i_d_victim      (d_victim),
		.i_i_miss        (icache_miss),
		.i_i_addr        (i_ifetch.addr[mem_geom_pkg::ADDR_W-1:2]),
		.i_d_addr        (i_dacc.addr[mem_geom_pkg::ADDR_W-1:2]),
		.o_d_fill_valid  (dcache_fill),
		.o_i_fill_valid  (icache_fill),
		.o_fill_line     (fill_line),
		.o_mem_req_valid (mem_req_valid),
		.o_mem_req       (mem_req),
		.i_rsp_valid     (rsp_valid),
		.i_rsp           (rsp),
		.i_credit        (credit)
	);

	unified_mem #(
		.MEM_LAT     (MEM_LAT),
		.MEM_CREDITS (MEM_CREDITS)
	) u_umem (
		.clk         (clk),
		.i_arst_n    (i_arst_n),
		.i_req_valid (mem_req_valid),
		.i_req       (mem_req),
		.o_rsp_valid (rsp_valid),
		.o_rsp       (rsp),
		.o_credit    (credit)
	);

endmodule

`default_nettype wire

//--- verif/tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// One entry per word address that starts at zero like the backing array
logic [15:0] model_mem [65536];
logic [31:0] rng_state = 32'd70946;
int          check_count = 0;
int          error_count = 0;

task model_clear();
	for (int a = 0; a < 65536; a++) begin
		model_mem[a] = '0;
	end
endtask

// 13/17/5 xorshift that never reaches zero from a nonzero seed
function logic [31:0] next_rand();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

task check_value(input logic [15:0] got, input logic [15:0] exp, input string what);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("FAIL t=%0t: %s, read %h, expected %h", $time, what, got, exp);
	end
endtask

`endif

//--- verif/tb_mem_hierarchy.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_hierarchy;

	localparam int TIMEOUT = 200;

	logic                  clk;
	logic                  arst_n;
	mem_bus_pkg::cpu_req_t ifetch;
	mem_bus_pkg::cpu_req_t dacc;
	mem_geom_pkg::word_t   instr;
	mem_geom_pkg::word_t   d_rd_data;
	logic                  i_rdy;
	logic                  d_rdy;

	logic [15:0]           stored_addr [16];
	int                    errors_before;

	`include "tb_mem_model.svh"

	mem_hierarchy dut (
		.clk         (clk),
		.i_arst_n    (arst_n),
		.i_ifetch    (ifetch),
		.o_instr     (instr),
		.o_i_rdy     (i_rdy),
		.i_dacc      (dacc),
		.o_d_rd_data (d_rd_data),
		.o_d_rdy     (d_rdy)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Two tag bits and three index bits, so lines keep evicting each other
	function logic [15:0] conflict_addr(input logic [15:0] region);
		logic [31:0] r;
		r = next_rand();
		return region | (16'(r[1:0]) << 12) | (16'(r[4:2]) << 2) | 16'(r[6:5]);
	endfunction

	// Requests held until rdy, sampled on the falling edge
	task automatic access_pair(input bit use_i, input logic [15:0] iaddr, input bit use_d,
		input bit dwrite, input logic [15:0] daddr, input logic [15:0] dwdata);
		bit i_done;
		bit d_done;
		int cycles;
		i_done = !use_i;
		d_done = !use_d;
		cycles = 0;
		@(posedge clk);
		if (use_i) begin
			ifetch <= '{valid: 1'b1, write: 1'b0, addr: iaddr, wdata: '0};
		end
		if (use_d) begin
			dacc <= '{valid: 1'b1, write: dwrite, addr: daddr, wdata: dwdata};
		end
		while (!(i_done && d_done) && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (!i_done && i_rdy) begin
				i_done = 1'b1;
				check_value(instr, model_mem[iaddr], $sformatf("fetch %h", iaddr));
			end
			if (!d_done && d_rdy) begin
				d_done = 1'b1;
				if (dwrite) begin
					// Store lands on the coming edge
					model_mem[daddr] = dwdata;
				end else begin
					check_value(d_rd_data, model_mem[daddr], $sformatf("load %h", daddr));
				end
			end
			@(posedge clk);
			if (i_done) begin
				ifetch <= '0;
			end
			if (d_done) begin
				dacc <= '0;
			end
		end
		ifetch <= '0;
		dacc   <= '0;
		if (!i_done) begin
			error_count++;
			$display("Instruction port stalled, no rdy for fetch of %h", iaddr);
		end
		if (!d_done) begin
			error_count++;
			$display("Data port stalled, no rdy for access to %h", daddr);
		end
	endtask

	task automatic load_check(input logic [15:0] addr);
		access_pair(1'b0, '0, 1'b1, 1'b0, addr, '0);
	endtask

	task automatic store_word(input logic [15:0] addr, input logic [15:0] data);
		access_pair(1'b0, '0, 1'b1, 1'b1, addr, data);
	endtask

	task automatic fetch_check(input logic [15:0] addr);
		access_pair(1'b1, addr, 1'b0, 1'b0, '0, '0);
	endtask

	task report_test(input string name);
		$display("%s finished, %0d errors", name, error_count - errors_before);
		errors_before = error_count;
	endtask

	initial begin
		logic [15:0] addr;
		logic [15:0] base;
		int          order [4];
		int          j;
		int          tmp;
		arst_n        = 1'b0;
		ifetch        = '0;
		dacc          = '0;
		errors_before = 0;
		model_clear();
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;

		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value(16'(i_rdy), 16'd0, "fetch rdy after reset");
		check_value(16'(d_rdy), 16'd0, "data rdy after reset");
		addr = 16'(next_rand());
		load_check(addr);
		report_test("reset state");

		for (int n = 0; n < 150; n++) begin
			addr = conflict_addr(16'(next_rand() & 32'h4000));
			if (next_rand() & 32'h1) begin
				store_word(addr, 16'(next_rand()));
			end else begin
				load_check(addr);
			end
		end
		report_test("random data traffic");

		base  = 16'(next_rand() & 32'h7FFC);
		order = '{0, 1, 2, 3};
		for (int k = 3; k > 0; k--) begin
			j        = int'(next_rand() % 32'(k + 1));
			tmp      = order[k];
			order[k] = order[j];
			order[j] = tmp;
		end
		for (int k = 0; k < 4; k++) begin
			store_word(base + 16'(order[k]), 16'(next_rand()));
		end
		for (int k = 0; k < 4; k++) begin
			load_check(base + 16'(k));
		end
		load_check(base - 16'd1);
		load_check(base + 16'd4);
		report_test("store merge");

		for (int k = 0; k < 16; k++) begin
			stored_addr[k] = 16'(next_rand() & 32'h3FFF);
			store_word(stored_addr[k], 16'(next_rand()));
		end
		// Scratch line at every index pushes all dirty lines to memory
		for (int idx = 0; idx < 64; idx++) begin
			load_check(16'h8000 | 16'(idx << 2));
		end
		for (int k = 0; k < 16; k++) begin
			fetch_check(stored_addr[k]);
		end
		report_test("eviction then fetch");

		// Fetches stay below 0x4000, data above, so no stale fetch lines
		for (int n = 0; n < 40; n++) begin
			addr = conflict_addr(16'h0000);
			base = conflict_addr(16'h4000);
			access_pair(1'b1, addr, 1'b1, 1'(next_rand() & 32'h1), base, 16'(next_rand()));
		end
		report_test("concurrent misses");

		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+verif
hdl/mem_geom_pkg.sv
hdl/mem_bus_pkg.sv
hdl/direct_cache.sv
hdl/miss_controller.sv
hdl/unified_mem.sv
hdl/mem_hierarchy.sv
verif/tb_mem_hierarchy.sv
